//--- display_pkg.sv
// ####################
// display timing constants
// 720p60 frame layout and tmds symbol size
// ####################

package display_pkg;

    localparam int coord_w = 12;            // screen coordinate width

    // horizontal timing in pixels
    localparam int h_res   = 1280;          // active pixels
    localparam int h_fp    = 110;           // front porch
    localparam int h_sync  = 40;            // sync pulse
    localparam int h_bp    = 220;           // back porch
    localparam int h_total = 1650;          // full line incl blanking

    // vertical timing in lines
    localparam int v_res   = 720;           // active lines
    localparam int v_fp    = 5;             // front porch
    localparam int v_sync  = 5;             // sync pulse
    localparam int v_bp    = 20;            // back porch
    localparam int v_total = 750;           // full frame incl blanking

    localparam bit sync_active_high = 1'b1; // 720p uses positive sync

    localparam int symbol_w = 10;           // one tmds character

endpackage

//--- pong_pkg.sv
// ####################
// game object constants
// ball geometry, motion and colour depth
// ####################

package pong_pkg;

    localparam int ball_size = 16;      // side of square ball in pixels

    // step per frame, same on both axes for now
    localparam int ball_speed_x = 2;
    localparam int ball_speed_y = 2;

    // position after reset, top left corner
    localparam int ball_start_x = 0;
    localparam int ball_start_y = 0;

    localparam int colour_w = 8;        // bits per colour channel

endpackage

//--- display_timing.sv
// ####################
// display timing generator
// pixel and line counters with registered sync, de and frame pulse
// ####################
`timescale 1ns/1ps

module display_timing (
    input  logic                            clk_pix,
    input  logic                            arst_n,
    output logic [display_pkg::coord_w-1:0] sx,      // pixel in line
    output logic [display_pkg::coord_w-1:0] sy,      // line in frame
    output logic                            hsync,
    output logic                            vsync,
    output logic                            de,      // active video
    output logic                            animate  // start of vblank
);

    localparam int cw = display_pkg::coord_w;

    // sync windows and wrap points from the porch values
    localparam logic [cw-1:0] hs_start = cw'(display_pkg::h_res + display_pkg::h_fp);
    localparam logic [cw-1:0] hs_end   = cw'(hs_start + display_pkg::h_sync);
    localparam logic [cw-1:0] h_last   = cw'(hs_end + display_pkg::h_bp - 1);
    localparam logic [cw-1:0] vs_start = cw'(display_pkg::v_res + display_pkg::v_fp);
    localparam logic [cw-1:0] vs_end   = cw'(vs_start + display_pkg::v_sync);
    localparam logic [cw-1:0] v_last   = cw'(vs_end + display_pkg::v_bp - 1);

    logic [cw-1:0] sx_next;
    logic [cw-1:0] sy_next;
    logic          hs_next;
    logic          vs_next;
    logic          de_next;
    logic          an_next;

    // decode on the next counter value so outputs line up with sx/sy
    always_comb begin
        sx_next = (sx == h_last) ? '0 : sx + 1'b1;
        sy_next = sy;
        if (sx == h_last) begin
            sy_next = (sy == v_last) ? '0 : sy + 1'b1;  // new line
        end
        hs_next = ((sx_next >= hs_start) && (sx_next < hs_end)) ^ !display_pkg::sync_active_high;
        vs_next = ((sy_next >= vs_start) && (sy_next < vs_end)) ^ !display_pkg::sync_active_high;
        de_next = (sx_next < display_pkg::h_res) && (sy_next < display_pkg::v_res);
        an_next = (sx_next == '0) && (sy_next == display_pkg::v_res);
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx      <= '0;
            sy      <= '0;
            hsync   <= !display_pkg::sync_active_high;  // idle level
            vsync   <= !display_pkg::sync_active_high;
            de      <= 1'b1;                             // pixel 0,0 is active
            animate <= 1'b0;
        end else begin
            sx      <= sx_next;
            sy      <= sy_next;
            hsync   <= hs_next;
            vsync   <= vs_next;
            de      <= de_next;
            animate <= an_next;
        end
    end

    // counters never leave the blanked frame
    a_sx_range: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (sx < display_pkg::h_total) && (sy < display_pkg::v_total));

    // one frame pulse per frame
    a_animate_single: assert property (@(posedge clk_pix) disable iff (!arst_n)
        animate |=> !animate);

endmodule

//--- ball_motion.sv
// ####################
// ball motion
// steps the ball once per frame, bounces off edges
// ####################
`timescale 1ns/1ps

module ball_motion (
    input  logic                            clk_pix,
    input  logic                            arst_n,
    input  logic                            animate,  // once per frame
    output logic [display_pkg::coord_w-1:0] bx,       // ball left edge
    output logic [display_pkg::coord_w-1:0] by        // ball top edge
);

    localparam int cw = display_pkg::coord_w;

    localparam logic [cw-1:0] spx  = cw'(pong_pkg::ball_speed_x);
    localparam logic [cw-1:0] spy  = cw'(pong_pkg::ball_speed_y);
    // last position that still leaves room for a full step
    localparam logic [cw-1:0] x_hi =
        cw'(display_pkg::h_res - pong_pkg::ball_speed_x - pong_pkg::ball_size);
    localparam logic [cw-1:0] y_hi =
        cw'(display_pkg::v_res - pong_pkg::ball_speed_y - pong_pkg::ball_size);

    logic dx;  // 1 moves left
    logic dy;  // 1 moves up

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            bx <= cw'(pong_pkg::ball_start_x);
            by <= cw'(pong_pkg::ball_start_y);
            dx <= 1'b0;
            dy <= 1'b0;
        end else if (animate) begin
            if (bx >= x_hi) begin           // right edge
                dx <= 1'b1;
                bx <= bx - spx;
            end else if (bx < spx) begin    // left edge
                dx <= 1'b0;
                bx <= bx + spx;
            end else begin
                bx <= dx ? bx - spx : bx + spx;
            end

            if (by >= y_hi) begin           // bottom edge
                dy <= 1'b1;
                by <= by - spy;
            end else if (by < spy) begin    // top edge
                dy <= 1'b0;
                by <= by + spy;
            end else begin
                by <= dy ? by - spy : by + spy;
            end
        end
    end

    // bounce keeps the whole square on screen, frame after frame
    a_ball_on_screen: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (bx + pong_pkg::ball_size <= display_pkg::h_res) &&
        (by + pong_pkg::ball_size <= display_pkg::v_res));

endmodule

//--- pixel_render.sv
// ####################
// pixel renderer
// white ball on black, syncs delayed to match colour
// ####################
`timescale 1ns/1ps

module pixel_render (
    input  logic                             clk_pix,
    input  logic                             arst_n,
    input  logic [display_pkg::coord_w-1:0]  sx,
    input  logic [display_pkg::coord_w-1:0]  sy,
    input  logic                             hsync,
    input  logic                             vsync,
    input  logic                             de,
    input  logic [display_pkg::coord_w-1:0]  bx,
    input  logic [display_pkg::coord_w-1:0]  by,
    output logic [pong_pkg::colour_w-1:0]    red,
    output logic [pong_pkg::colour_w-1:0]    green,
    output logic [pong_pkg::colour_w-1:0]    blue,
    output logic                             hsync_d,  // aligned with colour
    output logic                             vsync_d,
    output logic                             de_d
);

    localparam logic [display_pkg::coord_w-1:0] bsz = display_pkg::coord_w'(pong_pkg::ball_size);

    logic hit;  // current pixel inside ball

    always_comb begin
        hit = (sx >= bx) && (sx < bx + bsz) && (sy >= by) && (sy < by + bsz);
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            red     <= '0;
            green   <= '0;
            blue    <= '0;
            hsync_d <= !display_pkg::sync_active_high;
            vsync_d <= !display_pkg::sync_active_high;
            de_d    <= 1'b0;
        end else begin
            red     <= (de && hit) ? '1 : '0;  // black in blanking
            green   <= (de && hit) ? '1 : '0;
            blue    <= (de && hit) ? '1 : '0;
            hsync_d <= hsync;
            vsync_d <= vsync;
            de_d    <= de;
        end
    end

endmodule

//--- tmds_encoder.sv
// ####################
// tmds encoder
// 8b/10b dvi coding on three channels, one cycle latency
// ####################
`timescale 1ns/1ps

module tmds_encoder (
    input  logic                             clk_pix,
    input  logic                             arst_n,
    input  logic [pong_pkg::colour_w-1:0]    red,
    input  logic [pong_pkg::colour_w-1:0]    green,
    input  logic [pong_pkg::colour_w-1:0]    blue,
    input  logic                             hsync,
    input  logic                             vsync,
    input  logic                             de,
    output logic [display_pkg::symbol_w-1:0] tmds_ch0,  // blue + syncs
    output logic [display_pkg::symbol_w-1:0] tmds_ch1,  // green
    output logic [display_pkg::symbol_w-1:0] tmds_ch2   // red
);

    localparam int cw = pong_pkg::colour_w;

    // control period characters, index is {c1, c0}
    function automatic logic [display_pkg::symbol_w-1:0] ctrl_sym(input logic [1:0] ctl);
        case (ctl)
            2'b00:   ctrl_sym = 10'b1101010100;
            2'b01:   ctrl_sym = 10'b0010101011;
            2'b10:   ctrl_sym = 10'b0101010100;
            default: ctrl_sym = 10'b1010101011;
        endcase
    endfunction

    for (genvar c = 0; c < 3; c++) begin : g_ch
        logic [cw-1:0]                   d;         // channel pixel byte
        logic [1:0]                      ct;        // channel control bits
        logic [3:0]                      n1_d;      // ones in input
        logic [3:0]                      n1_q;      // ones in q_m low byte
        logic                            use_xnor;
        logic [cw:0]                     q_m;       // transition minimised
        logic signed [5:0]               bal;       // ones minus zeros of q_m
        logic signed [5:0]               disp;      // running disparity
        logic [display_pkg::symbol_w-1:0] sym;

        assign d  = (c == 0) ? blue : (c == 1) ? green : red;
        assign ct = (c == 0) ? {vsync, hsync} : 2'b00;  // ch1/ch2 ctrl tied low

        always_comb begin
            n1_d     = 4'($countones(d));
            use_xnor = (n1_d > 4'd4) || ((n1_d == 4'd4) && !d[0]);
            q_m[0]   = d[0];
            for (int i = 1; i < cw; i++) begin
                q_m[i] = use_xnor ? ~(q_m[i-1] ^ d[i]) : (q_m[i-1] ^ d[i]);
            end
            q_m[cw]  = !use_xnor;  // records which chain was used
            n1_q     = 4'($countones(q_m[cw-1:0]));
            bal      = $signed({1'b0, n1_q, 1'b0}) - 6'sd8;
        end

        always_ff @(posedge clk_pix or negedge arst_n) begin
            if (!arst_n) begin
                sym  <= ctrl_sym(2'b00);  // syncs inactive
                disp <= '0;
            end else if (!de) begin
                sym  <= ctrl_sym(ct);
                disp <= '0;               // blanking restarts balance
            end else if ((disp == 0) || (bal == 0)) begin
                sym  <= {~q_m[cw], q_m[cw], q_m[cw] ? q_m[cw-1:0] : ~q_m[cw-1:0]};
                disp <= q_m[cw] ? disp + bal : disp - bal;
            end else if (((disp > 0) && (bal > 0)) || ((disp < 0) && (bal < 0))) begin
                // invert to pull back toward zero
                sym  <= {1'b1, q_m[cw], ~q_m[cw-1:0]};
                disp <= disp - bal + (q_m[cw] ? 6'sd2 : 6'sd0);
            end else begin
                sym  <= {1'b0, q_m[cw], q_m[cw-1:0]};
                disp <= disp + bal - (q_m[cw] ? 6'sd0 : 6'sd2);
            end
        end

        // dc balance bounded while a line is being sent
        a_disp_bound: assert property (@(posedge clk_pix) disable iff (!arst_n)
            de |=> ((disp >= -6'sd8) && (disp <= 6'sd8)));
    end

    assign tmds_ch0 = g_ch[0].sym;
    assign tmds_ch1 = g_ch[1].sym;
    assign tmds_ch2 = g_ch[2].sym;

endmodule

//--- pong_top.sv
// ####################
// bouncing ball video core
// timing, motion, render and tmds encode at 720p
// ####################
`timescale 1ns/1ps

module pong_top (
    input  logic                             clk_pix,
    input  logic                             arst_n,
    output logic [display_pkg::symbol_w-1:0] tmds_ch0,
    output logic [display_pkg::symbol_w-1:0] tmds_ch1,
    output logic [display_pkg::symbol_w-1:0] tmds_ch2
);

    logic [display_pkg::coord_w-1:0] sx;
    logic [display_pkg::coord_w-1:0] sy;
    logic                            hsync;
    logic                            vsync;
    logic                            de;
    logic                            animate;   // frame tick for motion
    logic [display_pkg::coord_w-1:0] bx;
    logic [display_pkg::coord_w-1:0] by;
    logic [pong_pkg::colour_w-1:0]   red;
    logic [pong_pkg::colour_w-1:0]   green;
    logic [pong_pkg::colour_w-1:0]   blue;
    logic                            hsync_d;   // one stage behind counters
    logic                            vsync_d;
    logic                            de_d;

    display_timing i_display_timing (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .sx      (sx),
        .sy      (sy),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .animate (animate)
    );

    ball_motion i_ball_motion (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .animate (animate),
        .bx      (bx),
        .by      (by)
    );

    pixel_render i_pixel_render (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .sx      (sx),
        .sy      (sy),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .bx      (bx),
        .by      (by),
        .red     (red),
        .green   (green),
        .blue    (blue),
        .hsync_d (hsync_d),
        .vsync_d (vsync_d),
        .de_d    (de_d)
    );

    // second pipeline stage, symbols land two cycles after sx/sy
    tmds_encoder i_tmds_encoder (
        .clk_pix  (clk_pix),
        .arst_n   (arst_n),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .hsync    (hsync_d),
        .vsync    (vsync_d),
        .de       (de_d),
        .tmds_ch0 (tmds_ch0),
        .tmds_ch1 (tmds_ch1),
        .tmds_ch2 (tmds_ch2)
    );

endmodule

//--- tb_pong_top.sv
// ####################
// testbench for the bouncing ball video core
// decodes tmds, checks sync, image, motion and dc balance
// ####################
`timescale 1ns/1ps

module tb_pong_top;

    localparam int ht  = display_pkg::h_total;
    localparam int vt  = display_pkg::v_total;
    localparam int hs0 = display_pkg::h_res + display_pkg::h_fp;  // first hsync pixel
    localparam int vs0 = display_pkg::v_res + display_pkg::v_fp;  // first vsync line
    localparam int bs  = pong_pkg::ball_size;
    localparam int spx = pong_pkg::ball_speed_x;
    localparam int spy = pong_pkg::ball_speed_y;
    localparam logic [9:0] idle_sym = 10'b1101010100;             // ctrl bits 00

    logic                             clk_pix;
    logic                             arst_n;
    logic [display_pkg::symbol_w-1:0] ch [3];
    int         rx;                   // pixel now on the tmds outputs
    int         ry;
    int         ball_x;               // reference ball
    int         ball_y;
    int         dir_x;
    int         dir_y;
    int         first_x;              // top left white pixel seen this frame
    int         first_y;
    int         frames;
    int         bounces;
    int         ln_run;               // cycles since hsync rise
    int         hs_run;
    int         fr_run;               // cycles since vsync rise
    int         vs_run;
    logic       hs_q;
    logic       vs_q;
    int         err [6];
    int         n_fail;
    bit         timed_out;
    logic [2:0] c0;                   // {valid, vsync, hsync}
    logic [2:0] c1;
    logic [2:0] c2;
    logic [7:0] pix_exp;
    logic       hs;
    logic       vs;
    logic       exp_de;
    logic       exp_hs;
    logic       exp_vs;
    logic       in_ball;
    logic       white;

    // undo xor/xnor chaining after optional inversion
    function automatic logic [7:0] decode_data(input logic [9:0] s);
        logic [7:0] q;
        logic [7:0] d;
        q    = s[9] ? ~s[7:0] : s[7:0];
        d[0] = q[0];
        for (int i = 1; i < 8; i++) d[i] = s[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
        return d;
    endfunction

    function automatic logic [2:0] decode_ctrl(input logic [9:0] s);
        case (s)
            10'b1101010100: return 3'b100;
            10'b0010101011: return 3'b101;
            10'b0101010100: return 3'b110;
            10'b1010101011: return 3'b111;
            default:        return 3'b000;  // data character
        endcase
    endfunction

    // direction after the edge test, 0 in means 0 out when no edge is hit
    function automatic int bounce_dir(input int p, input int dir, input int sp, input int res);
        if (p >= res - sp - bs) return -1;
        else if (p < sp) return 1;
        return dir;
    endfunction

    task automatic log_error(input int test, input string msg);
        err[test] = err[test] + 1;
        $display("FAILED %0t: %s", $time, msg);
    endtask

    task automatic report_test(input int test, input string name);
        $display("test %s: %0d errors", name, err[test]);
        if (err[test] != 0) n_fail = n_fail + 1;
    endtask

    task automatic wait_frame(input int n);
        int guard;
        guard = 0;
        while ((frames < n) && (guard < ht * vt + ht)) begin
            @(posedge clk_pix);
            guard++;
        end
        if (frames < n) begin
            $display("timeout: frame %0d did not arrive within %0d cycles", n, guard);
            timed_out = 1'b1;
        end
    endtask

    pong_top i_pong_top (
        .clk_pix  (clk_pix),
        .arst_n   (arst_n),
        .tmds_ch0 (ch[0]),
        .tmds_ch1 (ch[1]),
        .tmds_ch2 (ch[2])
    );

    always_comb begin
        c0      = decode_ctrl(ch[0]);
        c1      = decode_ctrl(ch[1]);
        c2      = decode_ctrl(ch[2]);
        hs      = c0[2] & c0[0];
        vs      = c0[2] & c0[1];
        exp_de  = (rx < display_pkg::h_res) && (ry < display_pkg::v_res);
        exp_hs  = (rx >= hs0) && (rx < hs0 + display_pkg::h_sync);
        exp_vs  = (ry >= vs0) && (ry < vs0 + display_pkg::v_sync);
        in_ball = exp_de && (rx >= ball_x) && (rx < ball_x + bs)
                  && (ry >= ball_y) && (ry < ball_y + bs);
        pix_exp = in_ball ? 8'hFF : 8'h00;
        white   = !c0[2] && (decode_data(ch[0]) == 8'hFF) && (decode_data(ch[1]) == 8'hFF)
                  && (decode_data(ch[2]) == 8'hFF);
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            rx      <= ht - 2;          // two stage pipe, pixel 0,0 lands on edge two
            ry      <= vt - 1;
            ball_x  <= pong_pkg::ball_start_x;
            ball_y  <= pong_pkg::ball_start_y;
            dir_x   <= 1;
            dir_y   <= 1;
            first_x <= -1;
            first_y <= -1;
            frames  <= 0;
            bounces <= 0;
            ln_run  <= 0;
            hs_run  <= 0;
            fr_run  <= 0;
            vs_run  <= 0;
            hs_q    <= 1'b0;
            vs_q    <= 1'b0;
        end else begin
            rx     <= (rx == ht - 1) ? 0 : rx + 1;
            if (rx == ht - 1) ry <= (ry == vt - 1) ? 0 : ry + 1;
            hs_q   <= hs;
            vs_q   <= vs;
            hs_run <= hs ? hs_run + 1 : 0;
            vs_run <= vs ? vs_run + 1 : 0;
            ln_run <= (hs && !hs_q) ? 1 : (ln_run > 0) ? ln_run + 1 : 0;
            fr_run <= (vs && !vs_q) ? 1 : (fr_run > 0) ? fr_run + 1 : 0;
            if ((rx == 0) && (ry == display_pkg::v_res)) begin  // vblank, step ball
                dir_x   <= bounce_dir(ball_x, dir_x, spx, display_pkg::h_res);
                dir_y   <= bounce_dir(ball_y, dir_y, spy, display_pkg::v_res);
                ball_x  <= ball_x + spx * bounce_dir(ball_x, dir_x, spx, display_pkg::h_res);
                ball_y  <= ball_y + spy * bounce_dir(ball_y, dir_y, spy, display_pkg::v_res);
                // edge position as seen in the decoded image
                if ((first_x >= 0)
                    && ((bounce_dir(first_x, 0, spx, display_pkg::h_res) != 0)
                        || (bounce_dir(first_y, 0, spy, display_pkg::v_res) != 0))) begin
                    bounces <= bounces + 1;
                end
                frames  <= frames + 1;
                first_x <= -1;
                first_y <= -1;
            end else if (white && (first_x < 0)) begin
                first_x <= rx;
                first_y <= ry;
            end
        end
    end

    a_reset_idle: assert property (@(negedge clk_pix)
        !arst_n |-> (ch[0] == idle_sym) && (ch[1] == idle_sym) && (ch[2] == idle_sym))
        else log_error(0, "outputs not idle during reset");
    a_line_len: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (hs && !hs_q) |-> (ln_run == 0) || (ln_run == ht))
        else log_error(1, $sformatf("line length %0d", ln_run));
    a_hs_width: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (!hs && hs_q) |-> (hs_run == display_pkg::h_sync))
        else log_error(1, $sformatf("hsync width %0d", hs_run));
    a_frame_len: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (vs && !vs_q) |-> (fr_run == 0) || (fr_run == vt * ht))
        else log_error(1, $sformatf("frame length %0d cycles", fr_run));
    a_vs_width: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (!vs && vs_q) |-> (vs_run == display_pkg::v_sync * ht))
        else log_error(1, $sformatf("vsync width %0d cycles", vs_run));
    a_ctrl_sym: assert property (@(posedge clk_pix) disable iff (!arst_n)
        !exp_de |-> c0[2] && (c1 == 3'b100) && (c2 == 3'b100) && (hs == exp_hs) && (vs == exp_vs))
        else log_error(2, $sformatf("bad control symbol near pixel %0d,%0d", rx, ry));
    a_image: assert property (@(posedge clk_pix) disable iff (!arst_n)
        exp_de |-> !c0[2] && !c1[2] && !c2[2] && (decode_data(ch[0]) == pix_exp)
        && (decode_data(ch[1]) == pix_exp) && (decode_data(ch[2]) == pix_exp))
        else log_error(3, $sformatf("wrong colour near pixel %0d,%0d", rx, ry));
    a_motion: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (rx == 0) && (ry == display_pkg::v_res) |-> (first_x == ball_x) && (first_y == ball_y))
        else log_error(4, $sformatf("ball at %0d,%0d, model %0d,%0d",
                                    first_x, first_y, ball_x, ball_y));

    for (genvar c = 0; c < 3; c++) begin : g_dc
        int disp;   // ones minus zeros since blanking
        int dnext;

        assign dnext = disp + 2 * $countones(ch[c]) - 10;

        always_ff @(posedge clk_pix or negedge arst_n) begin
            if (!arst_n) disp <= 0;
            else disp <= exp_de ? dnext : 0;
        end

        a_dc_bound: assert property (@(posedge clk_pix) disable iff (!arst_n)
            exp_de |-> (dnext >= -8) && (dnext <= 8))
            else log_error(5, $sformatf("channel %0d disparity %0d", c, dnext));
    end

    initial begin
        clk_pix = 1'b0;
        forever #5 clk_pix = ~clk_pix;
    end

    initial begin
        arst_n    = 1'b0;
        timed_out = 1'b0;
        n_fail    = 0;
        foreach (err[i]) err[i] = 0;
        repeat (5) @(posedge clk_pix);
        #1 arst_n = 1'b1;       // release just after an edge
        report_test(0, "reset_state");
        for (int f = 1; f <= 3; f++) begin
            if (!timed_out) wait_frame(f);
        end
        if (timed_out) begin
            $display(">>> FAIL");
            $finish;
        end else begin
            repeat (ht * 40) @(posedge clk_pix);  // past the last vsync
            if (bounces == 0) begin
                err[4] = err[4] + 1;
                $display("ball_motion: the ball never reached an edge");
            end
            report_test(1, "sync_timing");
            report_test(2, "control_symbols");
            report_test(3, "ball_image");
            report_test(4, "ball_motion");
            report_test(5, "dc_balance");
            $display("tests passed %0d, failed %0d", 6 - n_fail, n_fail);
            if (n_fail == 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

//--- project.f
display_pkg.sv
pong_pkg.sv
display_timing.sv
ball_motion.sv
pixel_render.sv
tmds_encoder.sv
pong_top.sv
tb_pong_top.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the bouncing ball testbench with verilator
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal \
        -f project.f --top-module tb_pong_top -o sim_pong \
    && ./obj_dir/sim_pong | tee /dev/stderr | grep -q ">>> PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
